// File: bench/predecodeVectors.hex
// input line: startOff startMask parcel0 .. parcel14
// expected line: slotEn jumpEn error slot0..slot7 jump0..jump3, slot = {class byte, offset}
// basic packing
0 2225 0001 1111 0004 2222 3333 002a 1111 2222 3333 0041 1111 2222 3333 00a3 5555
1f 1 0 200 082 105 029 80d 000 000 000 80d 000 000 000
// start offset 5
5 0449 00a3 1111 2222 0041 3333 4444 0040 1111 2222 3333 00ff 1111 2222 3333 4444
3 0 0 046 01a 000 000 000 000 000 000 000 000 000 000
// start offset 15
f 7fff 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001 0001
0 0 1 000 000 000 000 000 000 000 000 000 000 000 000
// class groups
0 5555 0022 1234 0025 1234 0062 1234 0063 1234 00b4 1234 00b5 1234 0080 1234 0030
ff 3 0 200 082 044 026 808 80a 00c 00e 808 80a 000 000
// indirect group forms, sys and shift
0 0155 00b6 1111 60b6 1111 20b6 1111 00ff 1111 002d 1111 1111 1111 1111 1111 1111
1f 7 0 c00 c02 804 016 108 000 000 000 c00 c02 804 000
// six jumps
0 007f 0001 00a3 00b4 00b5 20b6 00a7 00b4 1111 1111 1111 1111 1111 1111 1111 1111
7f f 0 200 801 802 803 804 805 806 000 801 802 803 804
// fifteen starts
0 7fff 0001 0001 0001 00a3 0001 0001 0001 0001 0001 0001 00a3 0001 0001 0001 0001
ff 3 1 200 201 202 803 204 205 206 207 803 80a 000 000
// start at the last parcel
e 4000 1111 1111 1111 1111 1111 1111 1111 1111 1111 1111 1111 1111 1111 1111 00b5
1 1 0 80e 000 000 000 000 000 000 000 80e 000 000 000
// offset 1 with an empty mask
1 0000 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff 00ff
0 0 0 000 000 000 000 000 000 000 000 000 000 000 000
// offset 3 over the basic bundle
3 2225 0001 1111 0004 2222 3333 002a 1111 2222 3333 0041 1111 2222 3333 00a3 5555
7 1 0 105 029 80d 000 000 000 000 000 80d 000 000 000

// File: list.f
hdl/bundlePkg.sv
hdl/isaPkg.sv
hdl/instrClassify.sv
hdl/boundaryScan.sv
hdl/slotCompact.sv
hdl/predecodeTop.sv
bench/predecodeTb.sv

// File: run.sh
#!/bin/sh
# build and run the predecoder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --assert -f list.f --top-module predecodeTb -o predecodeSim
out=$(./obj_dir/predecodeSim)
echo "$out"
echo "$out" | grep -q "Verification passed"

// File: bench/predecodeTb.sv
/*
  predecoder testbench: clock, reset, vector reader,
  LFSR back-pressure and idle cycles, output checks and report
*/

`timescale 1ns/1ps

module predecodeTb
  import bundlePkg::*;
();

  localparam int NumVec      = 10;
  localparam int WordsPerVec = 32;  // 17 input words, 15 expected words
  localparam int CycleLimit  = NumVec * 30 + 50;
  localparam logic [31:0] LfsrSeed = 32'h6734_f7f2;
  localparam logic [31:0] LfsrTaps = 32'h8020_0003;

  logic      clk;
  logic      arstN;
  logic      inValid;
  logic      inReady;
  bundleT    inBundle;
  logic      outValid;
  logic      outReady;
  predecOutT outData;

  logic [31:0] vecMem [0:NumVec*WordsPerVec-1];
  logic [31:0] lfsr;
  logic        inFire;
  int          cycleCount = 0;
  int          recvCount = 0;
  int          passCount = 0;
  int          failCount = 0;
  int          protoErrs = 0;
  bit          timedOut = 0;
  bit          holdPending = 0;
  predecOutT   heldData;

  predecodeTop #(
    .SlotCount    (MaxSlots),
    .JumpSlotCount(MaxJumpSlots)
  ) predecodeTop_i (
    .clk     (clk),
    .arstN   (arstN),
    .inValid (inValid),
    .inReady (inReady),
    .inBundle(inBundle),
    .outValid(outValid),
    .outReady(outReady),
    .outData (outData)
  );

  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  task automatic takeBit(output logic b);
    lfsr = lfsrNext(lfsr);
    b    = lfsr[0];
  endtask

  function automatic string testName(input int v);
    case (v)
      0: return "basic packing";
      1: return "start offset 5";
      2: return "start offset 15";
      3: return "class groups";
      4: return "indirect group";
      5: return "jump slots";
      6: return "slot overflow";
      7: return "last parcel";
      8: return "no valid start";
      default: return "offset 3 repack";
    endcase
  endfunction

  function automatic bundleT bundleFor(input int v);
    bundleT b;
    int     base;
    base       = v * WordsPerVec;
    b.startOff = vecMem[base][3:0];
    b.starts   = vecMem[base+1][ParcelCount-1:0];
    for (int k = 0; k < ParcelCount; k++) begin
      b.parcels[k] = vecMem[base+2+k][15:0];
    end
    return b;
  endfunction

  // descriptor is {class byte, parcel offset}; word comes from parcels k and k+1
  function automatic slotT slotFrom(input int v, input logic [31:0] desc);
    slotT s;
    int   k;
    int   base;
    base   = v * WordsPerVec;
    k      = int'(desc[3:0]);
    s      = '0;
    s.off  = desc[3:0];
    s.cls  = desc[11:4];
    s.word[15:0] = vecMem[base+2+k][15:0];
    if (k + 1 < ParcelCount) begin
      s.word[31:16] = vecMem[base+3+k][15:0];  // past parcel 14 reads zero
    end
    return s;
  endfunction

  function automatic predecOutT expectedFor(input int v);
    predecOutT e;
    int        base;
    base     = v * WordsPerVec;
    e        = '0;
    e.slotEn = vecMem[base+17][MaxSlots-1:0];
    e.jumpEn = vecMem[base+18][MaxJumpSlots-1:0];
    e.error  = vecMem[base+19][0];
    for (int s = 0; s < MaxSlots; s++) begin
      if (e.slotEn[s]) e.slots[s] = slotFrom(v, vecMem[base+20+s]);
    end
    for (int j = 0; j < MaxJumpSlots; j++) begin
      if (e.jumpEn[j]) e.jumpSlots[j] = slotFrom(v, vecMem[base+28+j]);
    end
    return e;
  endfunction

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // stimulus, all driven on the falling edge
  initial begin
    logic bitVal;
    bit   rolled;
    int   sendIdx;
    arstN    = 1'b0;
    inValid  = 1'b0;
    outReady = 1'b0;
    inBundle = '0;
    lfsr     = LfsrSeed;
    rolled   = 0;
    sendIdx  = 0;
    $readmemh("bench/predecodeVectors.hex", vecMem);
    repeat (4) @(negedge clk);
    arstN = 1'b1;
    assert (inReady && !outValid) else begin
      $display("DUT not idle after reset: inReady=%b outValid=%b", inReady, outValid);
      protoErrs++;
    end
    forever begin
      @(negedge clk);
      takeBit(bitVal);
      outReady = bitVal;
      if (inValid && inFire) begin
        inValid = 1'b0;
        sendIdx++;
        rolled  = 0;
      end
      if (!inValid && sendIdx < NumVec) begin
        if (!rolled) begin
          takeBit(bitVal);  // one idle cycle when set
          rolled = 1;
        end else begin
          bitVal = 1'b0;
        end
        if (!bitVal) begin
          inBundle = bundleFor(sendIdx);
          inValid  = 1'b1;
        end
      end
    end
  end

  always @(posedge clk) begin
    inFire <= inValid && inReady;
  end

  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount >= CycleLimit) timedOut = 1;
  end

  always @(posedge clk) begin
    predecOutT expData;
    bit        good;
    if (holdPending) begin
      assert (outValid && outData === heldData) else begin
        $display("output changed while stalled before %s", testName(recvCount));
        protoErrs++;
      end
    end
    holdPending = outValid && !outReady;
    heldData    = outData;
    if (outValid && outReady) begin
      if (recvCount >= NumVec) begin
        $display("unexpected extra output after the last test");
        protoErrs++;
      end else begin
        expData = expectedFor(recvCount);
        good    = outData === expData;
        assert (good) else begin
          $display("ERR %s expected %h actual %h", testName(recvCount), expData, outData);
          failCount++;
        end
        if (good) begin
          passCount++;
          $display("%s: ok", testName(recvCount));
        end else begin
          $display("%s: mismatch", testName(recvCount));
        end
        recvCount++;
      end
    end
  end

  initial begin
    wait (recvCount == NumVec || timedOut);
    repeat (2) @(negedge clk);
    if (recvCount < NumVec) begin
      $display("timeout: outputs stopped arriving, %0d of %0d tests seen after %0d cycles",
               recvCount, NumVec, cycleCount);
    end
    $display("tests ok %0d, mismatched %0d, missing %0d, protocol errors %0d",
             passCount, failCount, NumVec - recvCount, protoErrs);
    if (recvCount == NumVec && failCount == 0 && protoErrs == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// File: hdl/predecodeTop.sv
/*
  predecoder top: scan stage followed by the packing stage
*/

`timescale 1ns/1ps

module predecodeTop
  import bundlePkg::*;
#(
  parameter int SlotCount     = MaxSlots,
  parameter int JumpSlotCount = MaxJumpSlots
) (
  input  logic      clk,
  input  logic      arstN,
  input  logic      inValid,
  output logic      inReady,
  input  bundleT    inBundle,
  output logic      outValid,
  input  logic      outReady,
  output predecOutT outData
);

  logic scanValid;
  logic scanReady;
  scanT scan;

  boundaryScan #(
    .SlotCount    (SlotCount),
    .JumpSlotCount(JumpSlotCount)
  ) boundaryScan_i (
    .clk      (clk),
    .arstN    (arstN),
    .inValid  (inValid),
    .inReady  (inReady),
    .inBundle (inBundle),
    .scanValid(scanValid),
    .scanReady(scanReady),
    .scan     (scan)
  );

  slotCompact #(
    .SlotCount    (SlotCount),
    .JumpSlotCount(JumpSlotCount)
  ) slotCompact_i (
    .clk      (clk),
    .arstN    (arstN),
    .scanValid(scanValid),
    .scanReady(scanReady),
    .scan     (scan),
    .outValid (outValid),
    .outReady (outReady),
    .outData  (outData)
  );

endmodule

// File: hdl/slotCompact.sv
/*
  stage 2: rank-based packing into instruction and jump slots,
  enables, error flag and the output register
*/

`timescale 1ns/1ps

module slotCompact
  import bundlePkg::*;
#(
  parameter int SlotCount     = MaxSlots,
  parameter int JumpSlotCount = MaxJumpSlots
) (
  input  logic      clk,
  input  logic      arstN,
  input  logic      scanValid,
  output logic      scanReady,
  input  scanT      scan,
  output logic      outValid,
  input  logic      outReady,
  output predecOutT outData
);

  slotT [ParcelCount-1:0] cand;
  predecOutT              outNext;

  // slot contents as seen from every parcel
  always_comb begin
    for (int k = 0; k < ParcelCount; k++) begin
      cand[k].word = scan.words[k];
      cand[k].cls  = scan.cls[k];
      cand[k].off  = offsetT'(k);
    end
  end

  always_comb begin
    outNext = '0;  // unused slots stay zero

    // at most one selected parcel carries a given rank
    for (int s = 0; s < SlotCount; s++) begin
      for (int k = 0; k < ParcelCount; k++) begin
        if (scan.slotSel[k] && scan.instrRank[k] == rankT'(s)) begin
          outNext.slots[s]  = cand[k];
          outNext.slotEn[s] = 1'b1;
        end
      end
    end

    for (int j = 0; j < JumpSlotCount; j++) begin
      for (int k = 0; k < ParcelCount; k++) begin
        if (scan.jumpSel[k] && scan.jumpRank[k] == rankT'(j)) begin
          outNext.jumpSlots[j] = cand[k];
          outNext.jumpEn[j]    = 1'b1;
        end
      end
    end

    // a valid start left without a slot means overflow
    outNext.error = scan.offErr || ((scan.starts & ~scan.slotSel) != '0);
  end

  assign scanReady = ~outValid | outReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      outValid <= 1'b0;
    end else if (scanReady) begin
      outValid <= scanValid;
    end
  end

  always_ff @(posedge clk) begin
    if (scanValid && scanReady) begin
      outData <= outNext;
    end
  end

endmodule

// File: hdl/boundaryScan.sv
/*
  stage 1: offset masking, per-parcel classification,
  instruction and jump ranks; also the scanT struct
*/

`timescale 1ns/1ps

// stage 1 to stage 2 payload, indexed by parcel
typedef struct packed {
  bundlePkg::classBitsT [bundlePkg::ParcelCount-1:0] cls;
  bundlePkg::instrWordT [bundlePkg::ParcelCount-1:0] words;
  bundlePkg::startMaskT                              starts;   // valid starts
  bundlePkg::startMaskT                              slotSel;  // start with a free slot
  bundlePkg::startMaskT                              jumpSel;  // jump with a free jump slot
  bundlePkg::rankT [bundlePkg::ParcelCount-1:0]      instrRank;
  bundlePkg::rankT [bundlePkg::ParcelCount-1:0]      jumpRank;
  logic                                              offErr;
} scanT;

module boundaryScan
  import bundlePkg::*;
  import isaPkg::*;
#(
  parameter int SlotCount     = MaxSlots,
  parameter int JumpSlotCount = MaxJumpSlots
) (
  input  logic   clk,
  input  logic   arstN,
  input  logic   inValid,
  output logic   inReady,
  input  bundleT inBundle,
  output logic   scanValid,
  input  logic   scanReady,
  output scanT   scan
);

  parcelT [ParcelCount:0]      parcelsExt;
  instrWordT [ParcelCount-1:0] wordAt;
  classT [ParcelCount-1:0]     clsAt;
  startMaskT                   offMask;
  startMaskT                   starts;
  startMaskT                   jumpFlag;
  startMaskT                   jumps;
  scanT                        scanNext;

  // one zero parcel past the end for the last word
  assign parcelsExt = {parcelT'(0), inBundle.parcels};

  for (genvar k = 0; k < ParcelCount; k++) begin : gParcel
    assign offMask[k] = offsetT'(k) >= inBundle.startOff;
    assign wordAt[k]  = {parcelsExt[k+1], parcelsExt[k]};

    instrClassify classify_i (
      .word(wordAt[k]),
      .cls (clsAt[k])
    );

    assign jumpFlag[k] = clsAt[k].jump;
  end

  assign starts = (inBundle.starts | startMaskT'(1)) & offMask;
  assign jumps  = starts & jumpFlag;

  // running prefix counts give each parcel its rank
  always_comb begin
    rankT instrCnt;
    rankT jumpCnt;
    instrCnt = '0;
    jumpCnt  = '0;
    scanNext = '0;
    for (int k = 0; k < ParcelCount; k++) begin
      scanNext.words[k]     = wordAt[k];
      scanNext.cls[k]       = clsAt[k];
      scanNext.instrRank[k] = instrCnt;
      scanNext.jumpRank[k]  = jumpCnt;
      scanNext.slotSel[k]   = starts[k] && (instrCnt < SlotCount);
      scanNext.jumpSel[k]   = jumps[k] && (jumpCnt < JumpSlotCount);
      instrCnt = instrCnt + rankT'(starts[k]);
      jumpCnt  = jumpCnt + rankT'(jumps[k]);
    end
    scanNext.starts = starts;
    scanNext.offErr = inBundle.startOff == offsetT'(ParcelCount);
  end

  assign inReady = ~scanValid | scanReady;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      scanValid <= 1'b0;
    end else if (inReady) begin
      scanValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (inValid && inReady) begin
      scan <= scanNext;
    end
  end

endmodule

// File: hdl/instrClassify.sv
/*
  instruction word to class flags,
  via the opcode group of the low byte
*/

`timescale 1ns/1ps

module instrClassify
  import bundlePkg::*;
  import isaPkg::*;
(
  input  instrWordT word,
  output classT     cls
);

  logic [7:0] opc;
  logic [2:0] sub;
  opGroupE    grp;

  assign opc = word[7:0];
  assign sub = word[15:13];  // form select of the indirect group

  always_comb begin
    if (opc[7:5] == 3'b000 || opc[7:3] == 5'b00100) begin
      grp = opc[2] ? mulOp : aluOp;
    end else if (opc >= OpShiftLo && opc <= OpShiftHi) begin
      grp = shiftOp;
    end else if (opc[7:5] == 3'b010 || opc[7:4] == 4'b0110) begin
      grp = memOp;
    end else if (opc[7:4] == OpCondJumpHi4 || opc == OpLongCondJump) begin
      grp = condJumpOp;
    end else if (opc == OpUncondJump) begin
      grp = uncondJumpOp;
    end else if (opc == OpIndirGroup) begin
      grp = indirGroupOp;
    end else if (opc == OpSys) begin
      grp = sysOp;
    end else begin
      grp = otherOp;
    end
  end

  always_comb begin
    cls = '0;
    case (grp)
      aluOp:   cls.alu = 1'b1;
      mulOp:   cls.mul = 1'b1;
      shiftOp: cls.shift = 1'b1;
      memOp: begin
        cls.store = opc[0];  // odd opcodes store
        cls.load  = ~opc[0];
      end
      condJumpOp,
      uncondJumpOp: cls.jump = 1'b1;
      indirGroupOp: begin
        cls.jump  = 1'b1;
        // indirect jump and return both go through a register
        cls.indir = (sub == IndirSubJump) || (sub == IndirSubRet);
      end
      sysOp:   cls.sys = 1'b1;
      default: cls = '0;
    endcase
  end

endmodule

// File: hdl/isaPkg.sv
/*
  instruction set view of the predecoder: opcode groups,
  class flag struct and the opcode values it decodes
*/

package isaPkg;

  typedef enum logic [3:0] {
    aluOp,
    mulOp,
    shiftOp,
    memOp,
    condJumpOp,
    uncondJumpOp,
    indirGroupOp,
    sysOp,
    otherOp
  } opGroupE;

  // several flags may be set for one instruction
  typedef struct packed {
    logic jump;
    logic indir;
    logic alu;
    logic shift;
    logic mul;
    logic load;
    logic store;
    logic sys;
  } classT;

  // shift range, inclusive
  localparam logic [7:0] OpShiftLo = 8'd40;
  localparam logic [7:0] OpShiftHi = 8'd45;

  // short conditional jumps share the high nibble
  localparam logic [3:0] OpCondJumpHi4 = 4'hA;

  localparam logic [7:0] OpLongCondJump = 8'd180;
  localparam logic [7:0] OpUncondJump   = 8'd181;

  // jump, call and return share one opcode, told apart by bits 15:13
  localparam logic [7:0] OpIndirGroup = 8'd182;
  localparam logic [2:0] IndirSubJump = 3'd0;
  localparam logic [2:0] IndirSubRet  = 3'd3;

  localparam logic [7:0] OpSys = 8'hFF;

endpackage

// File: hdl/bundlePkg.sv
/*
  bundle format: parcel and mask widths, slot bounds,
  bundle, slot and predecoder output structs
*/

package bundlePkg;

  localparam int ParcelBits   = 16;
  localparam int ParcelCount  = 15;
  localparam int MaxSlots     = 8;
  localparam int MaxJumpSlots = 4;
  localparam int ClassBits    = 8;  // width of isaPkg::classT
  localparam int RankBits     = 4;

  typedef logic [ParcelBits-1:0]   parcelT;
  typedef logic [ParcelCount-1:0]  startMaskT;  // bit k set: instruction begins at parcel k
  typedef logic [3:0]              offsetT;
  typedef logic [RankBits-1:0]     rankT;
  typedef logic [2*ParcelBits-1:0] instrWordT;
  typedef logic [ClassBits-1:0]    classBitsT;

  // parcel 0 in the low bits
  typedef struct packed {
    parcelT [ParcelCount-1:0] parcels;
    startMaskT                starts;
    offsetT                   startOff;
  } bundleT;

  typedef struct packed {
    instrWordT word;
    classBitsT cls;
    offsetT    off;  // parcel index of the first parcel
  } slotT;

  typedef struct packed {
    slotT [MaxSlots-1:0]       slots;
    logic [MaxSlots-1:0]       slotEn;
    slotT [MaxJumpSlots-1:0]   jumpSlots;
    logic [MaxJumpSlots-1:0]   jumpEn;
    logic                      error;
  } predecOutT;

endpackage
